//--- bench/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for the first four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/fetch_asserts.sv
`default_nettype none

module fetch_asserts import fetch_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        in_ready,
    input dec_pkt_t    out_pkt,
    input logic        out_valid,
    input logic        out_ready,
    input logic        redirect_valid,
    input ctrl_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // queue head holds still under back-pressure
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_pkt))
        else begin
            fail_count++;
            $error("out_pkt changed while out_valid was stalled");
        end

    redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid)
        else begin
            fail_count++;
            $error("redirect_valid high on two consecutive cycles");
        end

    serial_closed: assert property (@(posedge clk) disable iff (!rst_n)
        (state == CTRL_SERIAL) |-> !in_ready)
        else begin
            fail_count++;
            $error("in_ready high during priv serialization");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!out_valid && !in_ready && !redirect_valid))
        else begin
            fail_count++;
            $error("handshake outputs active during reset");
        end

endmodule

bind fetch_predecode_top fetch_asserts fetch_asserts_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_ready       (in_ready),
    .out_pkt        (out_pkt),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .redirect_valid (redirect_valid),
    .state          (fetch_ctrl_inst.state)
);

`default_nettype wire

//--- bench/tb_fetch.sv
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PKTS = 600;
    localparam int TIMEOUT  = NUM_PKTS * 20;

    logic        clk;
    logic        rst_n;
    fetch_pkt_t  in_pkt = '0;
    logic        in_valid = 1'b0;
    logic        in_ready;
    dec_pkt_t    out_pkt;
    logic        out_valid;
    logic        out_ready = 1'b0;
    logic        redirect_valid;
    pc_t         redirect_pc;
    logic        priv_done = 1'b0;

    logic [31:0] seed = 32'd13194;
    dec_pkt_t    exp_q[$];
    dec_pkt_t    got;
    predec_t     pd;
    ctrl_state_t mstate = CTRL_RUN;
    pc_t         mtarget = '0;
    pc_t         redir_exp = '0;
    logic        redir_due = 1'b0;
    logic        uncond;
    logic        run_done;
    int          wrong_left = 0;
    int          priv_wait = 0;
    int          stall_left = 0;
    int          cycles = 0;
    int          in_count = 0;
    int          out_count = 0;
    int          drained = 0;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          assert_errs = 0;

    clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_predecode_top fetch_predecode_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_pkt         (in_pkt),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_pkt        (out_pkt),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .priv_done      (priv_done)
    );

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    // weighted mix of plain, priv and branch encodings
    function automatic inst_t gen_inst();
        logic [31:0] r;
        logic [4:0]  k;
        r = rand32();
        k = 5'(rand32());
        case (k)
            5'd5: return {5'b00111, r[26:16], 1'b1, r[14:0]};
            5'd6: return {8'h04, r[23:0]};
            5'd7: begin
                if (r[1:0] == 2'd0) return 32'h0648_3000;
                else if (r[1:0] == 2'd1) return 32'h0648_3400;
                else return {17'b0000011_0010010011, r[14:0]};
            end
            5'd8, 5'd9: return {5'b01010, r[26:0]};
            5'd10: return {5'b01011, r[26:0]};
            5'd11: return {4'b0110, r[27:0]};
            5'd12: return {6'b010011, r[25:0]};
            default: return r;
        endcase
    endfunction

    function automatic br_class_t class_of(inst_t i);
        casez (i[31:26])
            6'b01010?: return BR_UNCOND;
            6'b01011?, 6'b0110??, 6'b010010: return BR_PCREL;
            6'b010011: return BR_INDIRECT;
            default: return BR_NONE;
        endcase
    endfunction

    // {ibar, csr, tlb}
    function automatic logic [2:0] priv_bits(inst_t i);
        logic ibar;
        logic csr;
        logic tlb;
        ibar = (i[31:27] == 5'b00111) && i[15];
        csr  = (i[31:24] == 8'h04) && (i[9:5] != 5'd0);
        tlb  = (i == 32'h0648_3000) || (i == 32'h0648_3400) ||
               (i[31:15] == 17'b0000011_0010010011);
        return {ibar, csr, tlb};
    endfunction

    function automatic predec_t expect_predec(fetch_pkt_t p);
        logic [2:0] f0;
        logic [2:0] f1;
        br_class_t  c0;
        br_class_t  c1;
        predec_t    d;
        f1 = priv_bits(p.inst1);
        f0 = p.pc[2] ? 3'b000 : priv_bits(p.inst0);
        c1 = class_of(p.inst1);
        c0 = p.pc[2] ? BR_NONE : class_of(p.inst0);
        d.ibar_flag      = {f1[2], f0[2]};
        d.csr_flag       = {f1[1], f0[1]};
        d.tlb_flag       = {f1[0], f0[0]};
        d.priv_flag      = {|f1, |f0};
        d.branch_flag[1] = c1;
        d.branch_flag[0] = c0;
        if (c1 != BR_NONE) d.inst_btype = c1;
        else if (!p.pc[2] && c0 == BR_INDIRECT) d.inst_btype = BR_INDIRECT;
        else d.inst_btype = BR_NONE;
        d.inst_bpos = (c0 == BR_NONE);
        return d;
    endfunction

    function automatic pc_t expect_target(fetch_pkt_t p, predec_t d);
        inst_t       i;
        pc_t         base;
        logic [25:0] off;
        base = {p.pc[31:3], 3'b000};
        if (d.branch_flag[0] == BR_UNCOND) begin
            i = p.inst0;
        end else begin
            i = p.inst1;
            base = base + 32'd4;
        end
        off = {i[9:0], i[25:10]};
        return base + {{4{off[25]}}, off, 2'b00};
    endfunction

    // in drain a few wrong-path packets come before the target
    task automatic build_pkt(output fetch_pkt_t p);
        logic [31:0] r;
        r = rand32();
        if (mstate == CTRL_DRAIN && wrong_left == 0) begin
            p.pc = mtarget;
        end else begin
            p.pc = {4'h1, r[27:2], 2'b00};
            if (mstate == CTRL_DRAIN) wrong_left--;
        end
        p.inst0 = gen_inst();
        p.inst1 = gen_inst();
    endtask

    task automatic check_dec(input string name, input dec_pkt_t exp, input dec_pkt_t act);
        if (act !== exp) begin
            value_errs++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            value_errs++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic protocol_error(input string msg);
        proto_errs++;
        $display("%s at cycle %0d", msg, cycles);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            // pulse owed by the previous edge's transfer
            if (redirect_valid && !redir_due) protocol_error("unexpected redirect pulse");
            else if (!redirect_valid && redir_due) protocol_error("missing redirect pulse");
            else if (redirect_valid) check_pc("redirect target", redir_exp, redirect_pc);
            redir_due = 1'b0;

            if (mstate == CTRL_RUN && in_ready && !out_ready && exp_q.size() == QUEUE_DEPTH)
                protocol_error("in_ready high while the queue is full");

            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_error("output packet appeared with none expected");
                end else begin
                    got = exp_q.pop_front();
                    check_dec("output packet", got, out_pkt);
                    out_count++;
                    if (|got.predec.priv_flag) priv_wait = 1 + int'(rand32() % 6);
                end
            end

            if (in_valid && in_ready) begin
                in_count++;
                if (mstate == CTRL_SERIAL) begin
                    protocol_error("input accepted during priv stall");
                end else if (mstate == CTRL_RUN || in_pkt.pc == mtarget) begin
                    pd = expect_predec(in_pkt);
                    got = '{pkt: in_pkt, predec: pd};
                    exp_q.push_back(got);
                    uncond = (pd.branch_flag[0] == BR_UNCOND) ||
                             (pd.branch_flag[1] == BR_UNCOND);
                    if (uncond) begin
                        redir_due  = 1'b1;
                        redir_exp  = expect_target(in_pkt, pd);
                        mtarget    = redir_exp;
                        wrong_left = 1 + int'(rand32() % 3);
                    end
                    if (|pd.priv_flag) mstate = CTRL_SERIAL;
                    else if (uncond) mstate = CTRL_DRAIN;
                    else mstate = CTRL_RUN;
                end else begin
                    drained++;
                end
            end else if (mstate == CTRL_SERIAL && priv_done) begin
                mstate = CTRL_RUN;
            end

            run_done = (in_count >= NUM_PKTS) && (exp_q.size() == 0) && !redir_due &&
                       (mstate != CTRL_SERIAL);
            if (cycles >= TIMEOUT) begin
                $display("timeout after %0d cycles with %0d packets still expected",
                         cycles, exp_q.size());
                $display("=== FAIL ===");
                $finish;
            end else if (run_done) begin
                assert_errs = fetch_predecode_top_inst.fetch_asserts_inst.fail_count;
                $display(
                    "%0d value, %0d protocol, %0d assert errors; %0d in, %0d out, %0d drained",
                    value_errs, proto_errs, assert_errs, in_count, out_count, drained);
                if (value_errs + proto_errs + assert_errs == 0) begin
                    $display("=== PASS ===");
                end else begin
                    $display("=== FAIL ===");
                end
                $finish;
            end else begin
                priv_done <= 1'b0;
                if (priv_wait != 0) begin
                    priv_wait--;
                    if (priv_wait == 0) priv_done <= 1'b1;
                end
                // long decode stalls now and then, otherwise mostly ready
                if (stall_left != 0) begin
                    stall_left--;
                    out_ready <= 1'b0;
                end else if (rand32() % 32 == 0) begin
                    stall_left = 10 + int'(rand32() % 20);
                    out_ready <= 1'b0;
                end else begin
                    out_ready <= (rand32() % 4 != 0);
                end
                if (in_count >= NUM_PKTS) begin
                    in_valid <= 1'b0;
                end else if (!(in_valid && !in_ready)) begin
                    if (rand32() % 4 == 0) begin
                        in_valid <= 1'b0;
                    end else begin
                        build_pkt(got.pkt);
                        in_pkt   <= got.pkt;
                        in_valid <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/fetch_pkg.sv
verilog/pre_decoder.sv
verilog/branch_target.sv
verilog/fetch_queue.sv
verilog/fetch_ctrl.sv
verilog/fetch_predecode_top.sv
bench/clk_gen.sv
bench/fetch_asserts.sv
bench/tb_fetch.sv

//--- verilog/branch_target.sv
`default_nettype none

module branch_target import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       take,
    input  fetch_pkt_t pkt,
    input  predec_t    predec,
    output logic       redirect_valid,
    output pc_t        redirect_pc
);

    logic        sel0;
    logic        hit;
    inst_t       inst;
    pc_t         slot_pc;
    logic [25:0] offs26;
    pc_t         target;

    // first valid unconditional slot, slot 0 already masked by pre-decode
    assign sel0 = (predec.branch_flag[0] == BR_UNCOND);
    assign hit  = sel0 || (predec.branch_flag[1] == BR_UNCOND);
    assign inst = sel0 ? pkt.inst0 : pkt.inst1;

    assign slot_pc = {pkt.pc[PC_W-1:3], 3'b000} + (sel0 ? pc_t'(0) : pc_t'(4));
    // offs[25:16] sits in inst[9:0], offs[15:0] in inst[25:10]
    assign offs26  = {inst[9:0], inst[25:10]};
    assign target  = slot_pc + {{(PC_W-28){offs26[25]}}, offs26, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take && hit;
        end
    end

    always_ff @(posedge clk) begin
        if (take && hit) begin
            redirect_pc <= target;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  fetch_pkt_t in_pkt,
    input  predec_t    predec,
    input  logic       q_ready,
    input  pc_t        redirect_pc,
    input  logic       priv_done,
    output logic       enq,
    output logic       take
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        live;
    logic        pc_match;
    logic        xfer;
    logic        accept;
    logic        has_priv;
    logic        has_uncond;

    assign pc_match   = (in_pkt.pc == redirect_pc);
    assign has_priv   = |predec.priv_flag;
    assign has_uncond = (predec.branch_flag[0] == BR_UNCOND) ||
                        (predec.branch_flag[1] == BR_UNCOND);

    // input stays closed until the first edge after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    always_comb begin
        case (state)
            CTRL_RUN: begin
                in_ready = live && q_ready;
            end
            CTRL_DRAIN: begin
                // wrong-path packets are swallowed, the target needs queue space
                in_ready = !pc_match || q_ready;
            end
            default: begin
                in_ready = 1'b0;
            end
        endcase
    end

    assign xfer   = in_valid && in_ready;
    assign accept = xfer && ((state == CTRL_RUN) || ((state == CTRL_DRAIN) && pc_match));
    assign enq    = accept;
    assign take   = accept;

    always_comb begin
        state_nxt = state;
        if (accept) begin
            // priv beats redirect for the state, the redirect still goes out
            if (has_priv) begin
                state_nxt = CTRL_SERIAL;
            end else if (has_uncond) begin
                state_nxt = CTRL_DRAIN;
            end else begin
                state_nxt = CTRL_RUN;
            end
        end else if ((state == CTRL_SERIAL) && priv_done) begin
            state_nxt = CTRL_RUN;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_RUN;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int INST_W      = 32;
    localparam int PC_W        = 32;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [1:0]        br_class_t;
    // bit 1 is slot 1, bit 0 is slot 0
    typedef logic [1:0]        slot_flags_t;
    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [QPTR_W:0]   qcnt_t;

    localparam br_class_t BR_NONE     = 2'd0;
    localparam br_class_t BR_UNCOND   = 2'd1;
    localparam br_class_t BR_PCREL    = 2'd2;
    localparam br_class_t BR_INDIRECT = 2'd3;

    // opcode groups for pre-decode
    localparam logic [4:0]  OP5_IBAR     = 5'b00111;
    localparam logic [7:0]  OP8_CSR      = 8'b0000_0100;
    localparam inst_t       TLBWR_WORD   = 32'b0000011_0010010000_01100_00000_00000;
    localparam inst_t       TLBFILL_WORD = 32'b0000011_0010010000_01101_00000_00000;
    localparam logic [16:0] OP17_INVTLB  = 17'b0000011_0010010011;
    localparam logic [4:0]  OP5_B_BL     = 5'b01010;
    localparam logic [4:0]  OP5_BEQ_BNE  = 5'b01011;
    localparam logic [3:0]  OP4_BCMP     = 4'b0110;
    localparam logic [5:0]  OP6_BCXZ     = 6'b010010;
    localparam logic [5:0]  OP6_JIRL     = 6'b010011;

    typedef struct packed {
        pc_t   pc;
        inst_t inst0;
        inst_t inst1;
    } fetch_pkt_t;

    typedef struct packed {
        slot_flags_t     priv_flag;
        slot_flags_t     ibar_flag;
        slot_flags_t     csr_flag;
        slot_flags_t     tlb_flag;
        br_class_t [1:0] branch_flag;
        br_class_t       inst_btype;
        logic            inst_bpos;
    } predec_t;

    typedef struct packed {
        fetch_pkt_t pkt;
        predec_t    predec;
    } dec_pkt_t;

    typedef enum logic [1:0] {
        CTRL_RUN,
        CTRL_DRAIN,
        CTRL_SERIAL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/fetch_predecode_top.sv
`default_nettype none

module fetch_predecode_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_pkt_t in_pkt,
    input  logic       in_valid,
    output logic       in_ready,
    output dec_pkt_t   out_pkt,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       redirect_valid,
    output pc_t        redirect_pc,
    input  logic       priv_done
);

    predec_t  predec;
    dec_pkt_t q_wdata;
    logic     enq;
    logic     take;
    logic     q_ready;

    // queue entry is the raw packet plus its annotations
    assign q_wdata = '{pkt: in_pkt, predec: predec};

    pre_decoder pre_decoder_inst (
        .pkt    (in_pkt),
        .predec (predec)
    );

    branch_target branch_target_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .take           (take),
        .pkt            (in_pkt),
        .predec         (predec),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    fetch_queue fetch_queue_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq       (enq),
        .wdata     (q_wdata),
        .q_ready   (q_ready),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    fetch_ctrl fetch_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_pkt      (in_pkt),
        .predec      (predec),
        .q_ready     (q_ready),
        .redirect_pc (redirect_pc),
        .priv_done   (priv_done),
        .enq         (enq),
        .take        (take)
    );

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
`default_nettype none

module fetch_queue import fetch_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enq,
    input  dec_pkt_t wdata,
    output logic     q_ready,
    output dec_pkt_t out_pkt,
    output logic     out_valid,
    input  logic     out_ready
);

    dec_pkt_t mem [QUEUE_DEPTH];
    qptr_t    wr_ptr;
    qptr_t    rd_ptr;
    qcnt_t    count;
    logic     full;
    logic     deq;

    function automatic qptr_t next_ptr(qptr_t ptr);
        return (ptr == qptr_t'(QUEUE_DEPTH - 1)) ? qptr_t'(0) : ptr + qptr_t'(1);
    endfunction

    assign full      = (count == qcnt_t'(QUEUE_DEPTH));
    assign out_valid = (count != qcnt_t'(0));
    assign out_pkt   = mem[rd_ptr];
    assign deq       = out_valid && out_ready;
    // a full queue still takes a write when the head leaves this cycle
    assign q_ready   = !full || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (deq) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (enq && !deq) begin
                count <= count + qcnt_t'(1);
            end else if (deq && !enq) begin
                count <= count - qcnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pre_decoder.sv
`default_nettype none

module pre_decoder import fetch_pkg::*; (
    input  fetch_pkt_t pkt,
    output predec_t    predec
);

    logic        slot0_ok;
    slot_flags_t ibar;
    slot_flags_t csr;
    slot_flags_t tlb;
    br_class_t   cls0;
    br_class_t   cls1;

    function automatic logic is_ibar(inst_t inst);
        return (inst[31:27] == OP5_IBAR) && inst[15];
    endfunction

    // csrrd has rj == 0, only writes and exchanges count
    function automatic logic is_csr(inst_t inst);
        return (inst[31:24] == OP8_CSR) && (inst[9:5] != 5'd0);
    endfunction

    function automatic logic is_tlb(inst_t inst);
        return (inst == TLBWR_WORD) || (inst == TLBFILL_WORD) ||
               (inst[31:15] == OP17_INVTLB);
    endfunction

    function automatic br_class_t br_class(inst_t inst);
        br_class_t cls;
        if (inst[31:27] == OP5_B_BL) begin
            cls = BR_UNCOND;
        end else if ((inst[31:27] == OP5_BEQ_BNE) || (inst[31:28] == OP4_BCMP) ||
                     (inst[31:26] == OP6_BCXZ)) begin
            cls = BR_PCREL;
        end else if (inst[31:26] == OP6_JIRL) begin
            cls = BR_INDIRECT;
        end else begin
            cls = BR_NONE;
        end
        return cls;
    endfunction

    // pc[2] set means slot 0 lies before the fetch address
    assign slot0_ok = ~pkt.pc[2];

    assign ibar = {is_ibar(pkt.inst1), is_ibar(pkt.inst0) & slot0_ok};
    assign csr  = {is_csr(pkt.inst1), is_csr(pkt.inst0) & slot0_ok};
    assign tlb  = {is_tlb(pkt.inst1), is_tlb(pkt.inst0) & slot0_ok};
    assign cls0 = slot0_ok ? br_class(pkt.inst0) : BR_NONE;
    assign cls1 = br_class(pkt.inst1);

    always_comb begin
        predec.ibar_flag   = ibar;
        predec.csr_flag    = csr;
        predec.tlb_flag    = tlb;
        predec.priv_flag   = ibar | csr | tlb;
        predec.branch_flag = {cls1, cls0};
        // slot 1 wins, slot 0 only reports indirect
        if (cls1 != BR_NONE) begin
            predec.inst_btype = cls1;
        end else if (pkt.pc[2]) begin
            predec.inst_btype = BR_NONE;
        end else if (cls0 == BR_INDIRECT) begin
            predec.inst_btype = BR_INDIRECT;
        end else begin
            predec.inst_btype = BR_NONE;
        end
        predec.inst_bpos = (cls0 != BR_NONE) ? 1'b0 : 1'b1;
    end

endmodule

`default_nettype wire
